//--- Bender.yml
package:
  name: mem_subsystem

sources:
  - files:
      - verilog/mem_subsystem_pkg.sv
      - verilog/line_req_if.sv
      - verilog/data_req_decoder.sv
      - verilog/line_memory.sv
      - verilog/interrupt_unit.sv
      - verilog/response_merger.sv
      - verilog/mem_subsystem.sv

  - target: test
    files:
      - testbench/tb_mem_subsystem.sv

//--- testbench/tb_mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsystem;

   localparam int CLK_PERIOD  = 100;
   localparam int DRIVE_DELAY = 10;

   // Cycle budget of each test and a watchdog limit of twice their sum
   localparam int T_RANDOM_RW    = 700;
   localparam int T_FETCH        = 300;
   localparam int T_BACKPRESSURE = 200;
   localparam int T_INTERRUPT    = 400;
   localparam int T_MIXED        = 400;
   localparam int MAX_CYCLES     = 2 * (T_RANDOM_RW + T_FETCH + T_BACKPRESSURE +
                                        T_INTERRUPT + T_MIXED);

   logic                          clk;
   logic                          arst_n;
   logic                          req_valid;
   logic                          req_wr;
   mem_subsystem_pkg::line_addr_t req_addr;
   mem_subsystem_pkg::line_data_t req_wdata;
   logic                          req_ready;
   logic                          rsp_valid;
   mem_subsystem_pkg::line_data_t rsp_rdata;
   logic                          rsp_ready;
   logic                          fetch_valid;
   mem_subsystem_pkg::line_addr_t fetch_addr;
   logic                          fetch_ready;
   logic                          fetch_rsp_valid;
   mem_subsystem_pkg::line_data_t fetch_rsp_rdata;
   mem_subsystem_pkg::irq_vec_t   irq_lines;
   logic                          interrupt;

   // Reference model state
   mem_subsystem_pkg::line_data_t model_mem [mem_subsystem_pkg::mem_idx_t];
   mem_subsystem_pkg::line_data_t exp_q [$];
   mem_subsystem_pkg::line_data_t exp_head;
   mem_subsystem_pkg::line_data_t exp_fetch;
   mem_subsystem_pkg::irq_vec_t   model_mask;
   mem_subsystem_pkg::irq_vec_t   model_pend;
   int                            exp_count;
   logic                          exp_int;
   logic                          fetch_fired;
   logic                          armed;

   string                         test_name;
   int                            err_count;
   int                            errs_at_start;
   int                            pass_count;
   int                            fail_count;
   int                            cycles;
   logic                          rsp_random;
   mem_subsystem_pkg::mem_idx_t   written [$];

   mem_subsystem i_dut (
      .clk             (clk),
      .arst_n          (arst_n),
      .req_valid       (req_valid),
      .req_wr          (req_wr),
      .req_addr        (req_addr),
      .req_wdata       (req_wdata),
      .req_ready       (req_ready),
      .rsp_valid       (rsp_valid),
      .rsp_rdata       (rsp_rdata),
      .rsp_ready       (rsp_ready),
      .fetch_valid     (fetch_valid),
      .fetch_addr      (fetch_addr),
      .fetch_ready     (fetch_ready),
      .fetch_rsp_valid (fetch_rsp_valid),
      .fetch_rsp_rdata (fetch_rsp_rdata),
      .irq_lines       (irq_lines),
      .interrupt       (interrupt)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Model follows every transfer at the clock edge with pre-edge register values
   always @(posedge clk or negedge arst_n) begin
      mem_subsystem_pkg::irq_vec_t clear;
      mem_subsystem_pkg::irq_vec_t mask_next;
      mem_subsystem_pkg::mem_idx_t idx;
      if (!arst_n) begin
         exp_q.delete();
         model_mask  = '0;
         model_pend  = '0;
         exp_int     = 1'b0;
         fetch_fired = 1'b0;
         armed       = 1'b0;
         exp_count   = 0;
         exp_head    = '0;
      end else begin
         clear       = '0;
         mask_next   = model_mask;
         idx         = req_addr[mem_subsystem_pkg::MEM_IDX_W-1:0];
         armed       = 1'b1;
         exp_int     = |(model_pend & model_mask);
         fetch_fired = fetch_valid && fetch_ready;
         // Fetch sees the line before a write in the same cycle
         if (fetch_fired) begin
            exp_fetch = model_mem[fetch_addr[mem_subsystem_pkg::MEM_IDX_W-1:0]];
         end
         if (rsp_valid && rsp_ready && exp_q.size() != 0) begin
            void'(exp_q.pop_front());
         end
         if (req_valid && req_ready) begin
            if (&req_addr[mem_subsystem_pkg::IO_SEL_MSB:mem_subsystem_pkg::IO_SEL_LSB]) begin
               if (req_wr) begin
                  exp_q.push_back('0);
                  if (req_addr[0] == mem_subsystem_pkg::IO_REG_PENDING) begin
                     clear = req_wdata[mem_subsystem_pkg::IRQ_W-1:0];
                  end else begin
                     mask_next = req_wdata[mem_subsystem_pkg::IRQ_W-1:0];
                  end
               end else if (req_addr[0] == mem_subsystem_pkg::IO_REG_PENDING) begin
                  exp_q.push_back(mem_subsystem_pkg::line_data_t'(model_pend));
               end else begin
                  exp_q.push_back(mem_subsystem_pkg::line_data_t'(model_mask));
               end
            end else if (req_wr) begin
               exp_q.push_back('0);
               model_mem[idx] = req_wdata;
            end else begin
               exp_q.push_back(model_mem[idx]);
            end
         end
         model_pend = (model_pend & ~clear) | irq_lines;
         model_mask = mask_next;
         exp_count  = exp_q.size();
         exp_head   = (exp_count != 0) ? exp_q[0] : '0;
      end
   end

   a_rsp_expected: assert property (
      @(posedge clk) disable iff (!arst_n)
      rsp_valid |-> (exp_count != 0)
   ) else begin
      err_count++;
      $display("%s: response returned with no request outstanding", test_name);
   end

   a_rsp_data: assert property (
      @(posedge clk) disable iff (!arst_n)
      (rsp_valid && rsp_ready) |-> (rsp_rdata == exp_head)
   ) else begin
      err_count++;
      $display("ERR %s rsp_rdata expected %h actual %h",
               test_name, $sampled(exp_head), $sampled(rsp_rdata));
   end

   // Credit drops exactly when RSP_DEPTH responses are owed
   a_req_ready: assert property (
      @(posedge clk) disable iff (!arst_n)
      armed |-> (req_ready == (exp_count < mem_subsystem_pkg::RSP_DEPTH))
   ) else begin
      err_count++;
      $display("ERR %s req_ready expected %b actual %b", test_name,
               $sampled(exp_count) < mem_subsystem_pkg::RSP_DEPTH, $sampled(req_ready));
   end

   a_fetch_ready: assert property (
      @(posedge clk) disable iff (!arst_n)
      armed |-> fetch_ready
   ) else begin
      err_count++;
      $display("%s: fetch port not ready after reset", test_name);
   end

   a_fetch_valid: assert property (
      @(posedge clk) disable iff (!arst_n)
      fetch_rsp_valid == fetch_fired
   ) else begin
      err_count++;
      $display("ERR %s fetch_rsp_valid expected %b actual %b",
               test_name, $sampled(fetch_fired), $sampled(fetch_rsp_valid));
   end

   a_fetch_data: assert property (
      @(posedge clk) disable iff (!arst_n)
      fetch_rsp_valid |-> (fetch_rsp_rdata == exp_fetch)
   ) else begin
      err_count++;
      $display("ERR %s fetch_rsp_rdata expected %h actual %h",
               test_name, $sampled(exp_fetch), $sampled(fetch_rsp_rdata));
   end

   a_interrupt: assert property (
      @(posedge clk) disable iff (!arst_n)
      interrupt == exp_int
   ) else begin
      err_count++;
      $display("ERR %s interrupt expected %b actual %b",
               test_name, $sampled(exp_int), $sampled(interrupt));
   end

   // Random response stalls when enabled
   initial begin
      forever begin
         @(posedge clk);
         #DRIVE_DELAY;
         if (rsp_random) begin
            rsp_ready = ($urandom_range(0, 3) != 0);
         end
      end
   end

   initial begin
      cycles = 0;
      while (cycles < MAX_CYCLES) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout after %0d cycles, a request or response never completed", cycles);
      $display("SIMULATION FAILED");
      $finish;
   end

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge clk);
         #DRIVE_DELAY;
      end
   endtask

   // req_ready only moves at a clock edge, so it is stable here
   task automatic send(input logic wr, input mem_subsystem_pkg::line_addr_t addr,
                       input mem_subsystem_pkg::line_data_t wdata);
      req_valid = 1'b1;
      req_wr    = wr;
      req_addr  = addr;
      req_wdata = wdata;
      while (!req_ready) begin
         idle(1);
      end
      idle(1);
      req_valid = 1'b0;
   endtask

   task automatic fetch(input mem_subsystem_pkg::line_addr_t addr);
      fetch_valid = 1'b1;
      fetch_addr  = addr;
      while (!fetch_ready) begin
         idle(1);
      end
      idle(1);
      fetch_valid = 1'b0;
   endtask

   task automatic pulse_irq(input mem_subsystem_pkg::irq_vec_t lines);
      irq_lines = lines;
      idle(1);
      irq_lines = '0;
   endtask

   function automatic mem_subsystem_pkg::line_data_t rand_line();
      return {$urandom(), $urandom(), $urandom(), $urandom()};
   endfunction

   // Random high bits give aliases of the same line
   function automatic mem_subsystem_pkg::line_addr_t mem_addr(
         input mem_subsystem_pkg::mem_idx_t idx);
      mem_subsystem_pkg::line_addr_t addr;
      addr = mem_subsystem_pkg::line_addr_t'($urandom());
      addr[mem_subsystem_pkg::MEM_IDX_W-1:0] = idx;
      if (&addr[mem_subsystem_pkg::IO_SEL_MSB:mem_subsystem_pkg::IO_SEL_LSB]) begin
         addr[mem_subsystem_pkg::IO_SEL_LSB] = 1'b0;
      end
      return addr;
   endfunction

   function automatic mem_subsystem_pkg::line_addr_t io_addr(input logic sel);
      mem_subsystem_pkg::line_addr_t addr;
      addr = mem_subsystem_pkg::line_addr_t'($urandom());
      addr[mem_subsystem_pkg::IO_SEL_MSB:mem_subsystem_pkg::IO_SEL_LSB] = '1;
      addr[0] = sel;
      return addr;
   endfunction

   function automatic mem_subsystem_pkg::mem_idx_t pick_written();
      return written[$urandom_range(0, written.size() - 1)];
   endfunction

   task automatic wait_drained();
      while (exp_count != 0) begin
         idle(1);
      end
   endtask

   task automatic start_test(input string name);
      test_name     = name;
      errs_at_start = err_count;
   endtask

   task automatic end_test();
      wait_drained();
      idle(2);
      if (err_count == errs_at_start) begin
         pass_count++;
         $display("PASS %s", test_name);
      end else begin
         fail_count++;
         $display("FAIL %s with %0d errors", test_name, err_count - errs_at_start);
      end
   endtask

   task automatic test_random_rw();
      mem_subsystem_pkg::mem_idx_t idx;
      start_test("random_rw");
      rsp_random = 1'b1;
      for (int i = 0; i < 16; i++) begin
         idx = mem_subsystem_pkg::mem_idx_t'($urandom());
         written.push_back(idx);
         send(1'b1, mem_addr(idx), rand_line());
      end
      for (int i = 0; i < 200; i++) begin
         if ($urandom_range(0, 1) == 0) begin
            idx = ($urandom_range(0, 1) == 0) ? pick_written() :
                  mem_subsystem_pkg::mem_idx_t'($urandom());
            written.push_back(idx);
            send(1'b1, mem_addr(idx), rand_line());
         end else begin
            send(1'b0, mem_addr(pick_written()), '0);
         end
         if ($urandom_range(0, 3) == 0) begin
            idle(1);
         end
      end
      end_test();
   endtask

   task automatic test_fetch();
      mem_subsystem_pkg::mem_idx_t idx;
      start_test("fetch");
      rsp_random = 1'b0;
      rsp_ready  = 1'b1;
      for (int i = 0; i < 40; i++) begin
         idx = pick_written();
         fetch(mem_addr(idx));
         // Write and fetch of one line in the same cycle
         fork
            send(1'b1, mem_addr(idx), rand_line());
            fetch(mem_addr(idx));
         join
         fetch(mem_addr(idx));
      end
      end_test();
   endtask

   task automatic test_backpressure();
      start_test("backpressure");
      rsp_random = 1'b0;
      for (int round = 0; round < 5; round++) begin
         wait_drained();
         rsp_ready = 1'b0;
         for (int i = 0; i < mem_subsystem_pkg::RSP_DEPTH; i++) begin
            send(i[0], mem_addr(pick_written()), rand_line());
         end
         // Queue is full so ready has to stay low
         idle(4);
         fork
            begin
               send(1'b0, mem_addr(pick_written()), '0);
               send(1'b1, mem_addr(pick_written()), rand_line());
            end
            begin
               idle(3);
               rsp_ready = 1'b1;
            end
         join
      end
      end_test();
   endtask

   task automatic test_interrupt();
      start_test("interrupt");
      rsp_random = 1'b0;
      rsp_ready  = 1'b1;
      send(1'b1, io_addr(mem_subsystem_pkg::IO_REG_PENDING), '1);
      send(1'b1, io_addr(mem_subsystem_pkg::IO_REG_MASK), 128'h0f);
      // Masked lines alone leave interrupt low
      pulse_irq(8'ha0);
      idle(3);
      pulse_irq(8'h05);
      idle(3);
      send(1'b0, io_addr(mem_subsystem_pkg::IO_REG_PENDING), '0);
      send(1'b0, io_addr(mem_subsystem_pkg::IO_REG_MASK), '0);
      send(1'b1, io_addr(mem_subsystem_pkg::IO_REG_PENDING), 128'hff);
      idle(3);
      // Line still active while its bit is cleared
      irq_lines = 8'h02;
      send(1'b1, io_addr(mem_subsystem_pkg::IO_REG_PENDING), 128'h02);
      irq_lines = '0;
      send(1'b0, io_addr(mem_subsystem_pkg::IO_REG_PENDING), '0);
      for (int i = 0; i < 10; i++) begin
         send(1'b1, io_addr(mem_subsystem_pkg::IO_REG_MASK), rand_line());
         pulse_irq(mem_subsystem_pkg::irq_vec_t'($urandom()));
         idle(2);
         send(1'b0, io_addr(mem_subsystem_pkg::IO_REG_PENDING), '0);
         send(1'b1, io_addr(mem_subsystem_pkg::IO_REG_PENDING), rand_line());
         idle(2);
      end
      end_test();
   endtask

   task automatic test_mixed();
      logic sel;
      start_test("mixed");
      rsp_random = 1'b0;
      rsp_ready  = 1'b1;
      for (int i = 0; i < 60; i++) begin
         if (i[0] == 1'b0) begin
            sel       = ($urandom_range(0, 1) == 1);
            irq_lines = mem_subsystem_pkg::irq_vec_t'($urandom());
            send($urandom_range(0, 3) == 0, io_addr(sel), rand_line());
         end else if ($urandom_range(0, 1) == 0) begin
            send(1'b1, mem_addr(pick_written()), rand_line());
         end else begin
            send(1'b0, mem_addr(pick_written()), '0);
         end
      end
      irq_lines = '0;
      end_test();
   endtask

   initial begin
      void'($urandom(3443));
      arst_n      = 1'b0;
      req_valid   = 1'b0;
      req_wr      = 1'b0;
      req_addr    = '0;
      req_wdata   = '0;
      rsp_ready   = 1'b1;
      fetch_valid = 1'b0;
      fetch_addr  = '0;
      irq_lines   = '0;
      rsp_random  = 1'b0;
      err_count   = 0;
      pass_count  = 0;
      fail_count  = 0;
      test_name   = "reset";
      repeat (2) @(posedge clk);
      #DRIVE_DELAY;
      arst_n = 1'b1;
      idle(1);
      test_random_rw();
      test_fetch();
      test_backpressure();
      test_interrupt();
      test_mixed();
      $display("tests passed %0d, failed %0d", pass_count, fail_count);
      if (fail_count == 0 && err_count == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog.f
verilog/mem_subsystem_pkg.sv
verilog/line_req_if.sv
verilog/data_req_decoder.sv
verilog/line_memory.sv
verilog/interrupt_unit.sv
verilog/response_merger.sv
verilog/mem_subsystem.sv
testbench/tb_mem_subsystem.sv

//--- verilog/data_req_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module data_req_decoder (
   input  wire                           clk,
   input  wire                           arst_n,
   input  wire                           req_valid,
   input  wire                           req_wr,
   input  wire mem_subsystem_pkg::line_addr_t req_addr,
   input  wire mem_subsystem_pkg::line_data_t req_wdata,
   output logic                          req_ready,
   input  wire                           credit_ok,
   line_req_if.initiator                 mem_req,
   line_req_if.initiator                 io_req
);

   mem_subsystem_pkg::target_t target;
   logic                       running;
   logic                       accept;

   // Ready is held low through reset and rises on the first cycle after it
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         running <= 1'b0;
      end else begin
         running <= 1'b1;
      end
   end

   assign req_ready = running & credit_ok;
   assign accept    = req_valid & req_ready;

   // Address map decode
   always_comb begin
      if (&req_addr[mem_subsystem_pkg::IO_SEL_MSB:mem_subsystem_pkg::IO_SEL_LSB]) begin
         target = mem_subsystem_pkg::tgt_io;
      end else begin
         target = mem_subsystem_pkg::tgt_mem;
      end
   end

   // Only valid is steered and the payload goes to both targets
   assign mem_req.valid = accept && (target == mem_subsystem_pkg::tgt_mem);
   assign mem_req.wr    = req_wr;
   assign mem_req.addr  = req_addr;
   assign mem_req.wdata = req_wdata;

   assign io_req.valid  = accept && (target == mem_subsystem_pkg::tgt_io);
   assign io_req.wr     = req_wr;
   assign io_req.addr   = req_addr;
   assign io_req.wdata  = req_wdata;

   // Each transfer goes to exactly one target
   a_one_target: assert property (
      @(posedge clk) disable iff (!arst_n)
      !(mem_req.valid && io_req.valid)
   ) else $error("data request steered to memory and IO at once");

endmodule

`default_nettype wire

//--- verilog/interrupt_unit.sv
`timescale 1ns/1ps
`default_nettype none

module interrupt_unit (
   input  wire                             clk,
   input  wire                             arst_n,
   line_req_if.target                      io_req,
   output logic                            io_rsp_valid,
   output mem_subsystem_pkg::line_data_t   io_rsp_rdata,
   input  wire mem_subsystem_pkg::irq_vec_t irq_lines,
   output logic                            interrupt
);

   mem_subsystem_pkg::irq_vec_t mask_q;
   mem_subsystem_pkg::irq_vec_t pending_q;
   mem_subsystem_pkg::irq_vec_t clear;
   logic                        sel_mask;
   logic                        sel_pending;
   logic                        reg_wr;

   assign sel_mask    = (io_req.addr[0] == mem_subsystem_pkg::IO_REG_MASK);
   assign sel_pending = (io_req.addr[0] == mem_subsystem_pkg::IO_REG_PENDING);
   assign reg_wr      = io_req.valid & io_req.wr;

   // Write-one-to-clear on pending
   assign clear = (reg_wr && sel_pending) ?
                  io_req.wdata[mem_subsystem_pkg::IRQ_W-1:0] : '0;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         mask_q    <= '0;
         pending_q <= '0;
         interrupt <= 1'b0;
      end else begin
         if (reg_wr && sel_mask) begin
            mask_q <= io_req.wdata[mem_subsystem_pkg::IRQ_W-1:0];
         end
         // An active line wins over a clear in the same cycle
         pending_q <= (pending_q & ~clear) | irq_lines;
         interrupt <= |(pending_q & mask_q);
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         io_rsp_valid <= 1'b0;
      end else begin
         io_rsp_valid <= io_req.valid;
      end
   end

   // Register read, zero-extended to a full line
   always_ff @(posedge clk) begin
      if (io_req.valid) begin
         if (io_req.wr) begin
            io_rsp_rdata <= '0;
         end else if (sel_pending) begin
            io_rsp_rdata <= mem_subsystem_pkg::line_data_t'(pending_q);
         end else begin
            io_rsp_rdata <= mem_subsystem_pkg::line_data_t'(mask_q);
         end
      end
   end

endmodule

`default_nettype wire

//--- verilog/line_memory.sv
`timescale 1ns/1ps
`default_nettype none

module line_memory (
   input  wire                              clk,
   input  wire                              arst_n,
   line_req_if.target                       data_req,
   output logic                             data_rsp_valid,
   output mem_subsystem_pkg::line_data_t    data_rsp_rdata,
   input  wire                              fetch_valid,
   input  wire mem_subsystem_pkg::line_addr_t fetch_addr,
   output logic                             fetch_ready,
   output logic                             fetch_rsp_valid,
   output mem_subsystem_pkg::line_data_t    fetch_rsp_rdata
);

   mem_subsystem_pkg::line_data_t mem [mem_subsystem_pkg::MEM_DEPTH];

   mem_subsystem_pkg::mem_idx_t data_idx;
   mem_subsystem_pkg::mem_idx_t fetch_idx;
   logic                        fetch_accept;

   // High address bits are ignored, so addresses alias every 256 lines
   assign data_idx  = data_req.addr[mem_subsystem_pkg::MEM_IDX_W-1:0];
   assign fetch_idx = fetch_addr[mem_subsystem_pkg::MEM_IDX_W-1:0];

   assign fetch_accept = fetch_valid & fetch_ready;

   // Fetch port is always ready once out of reset
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         fetch_ready <= 1'b0;
      end else begin
         fetch_ready <= 1'b1;
      end
   end

   // Data port write
   always_ff @(posedge clk) begin
      if (data_req.valid && data_req.wr) begin
         mem[data_idx] <= data_req.wdata;
      end
   end

   // Data port response, writes answer with zero
   always_ff @(posedge clk) begin
      if (data_req.valid) begin
         if (data_req.wr) begin
            data_rsp_rdata <= '0;
         end else begin
            data_rsp_rdata <= mem[data_idx];
         end
      end
   end

   // Fetch read sees the contents before a write in the same cycle
   always_ff @(posedge clk) begin
      if (fetch_accept) begin
         fetch_rsp_rdata <= mem[fetch_idx];
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         data_rsp_valid  <= 1'b0;
         fetch_rsp_valid <= 1'b0;
      end else begin
         data_rsp_valid  <= data_req.valid;
         fetch_rsp_valid <= fetch_accept;
      end
   end

endmodule

`default_nettype wire

//--- verilog/line_req_if.sv
`timescale 1ns/1ps
`default_nettype none

// Decoded line request, one per target
interface line_req_if;

   logic                         valid;
   logic                         wr;
   mem_subsystem_pkg::line_addr_t addr;
   mem_subsystem_pkg::line_data_t wdata;

   // Decoder side
   modport initiator (
      output valid,
      output wr,
      output addr,
      output wdata
   );

   // Memory or interrupt unit side, no ready since credit is checked upstream
   modport target (
      input valid,
      input wr,
      input addr,
      input wdata
   );

endinterface

`default_nettype wire

//--- verilog/mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem (
   input  wire                              clk,
   input  wire                              arst_n,
   // Data port
   input  wire                              req_valid,
   input  wire                              req_wr,
   input  wire mem_subsystem_pkg::line_addr_t req_addr,
   input  wire mem_subsystem_pkg::line_data_t req_wdata,
   output logic                             req_ready,
   output logic                             rsp_valid,
   output mem_subsystem_pkg::line_data_t    rsp_rdata,
   input  wire                              rsp_ready,
   // Fetch port
   input  wire                              fetch_valid,
   input  wire mem_subsystem_pkg::line_addr_t fetch_addr,
   output logic                             fetch_ready,
   output logic                             fetch_rsp_valid,
   output mem_subsystem_pkg::line_data_t    fetch_rsp_rdata,
   // Interrupts
   input  wire mem_subsystem_pkg::irq_vec_t irq_lines,
   output logic                             interrupt
);

   logic                          credit_ok;
   logic                          mem_rsp_valid;
   mem_subsystem_pkg::line_data_t mem_rsp_rdata;
   logic                          io_rsp_valid;
   mem_subsystem_pkg::line_data_t io_rsp_rdata;

   line_req_if mem_req ();
   line_req_if io_req ();

   data_req_decoder i_decoder (
      .clk       (clk),
      .arst_n    (arst_n),
      .req_valid (req_valid),
      .req_wr    (req_wr),
      .req_addr  (req_addr),
      .req_wdata (req_wdata),
      .req_ready (req_ready),
      .credit_ok (credit_ok),
      .mem_req   (mem_req),
      .io_req    (io_req)
   );

   line_memory i_line_memory (
      .clk             (clk),
      .arst_n          (arst_n),
      .data_req        (mem_req),
      .data_rsp_valid  (mem_rsp_valid),
      .data_rsp_rdata  (mem_rsp_rdata),
      .fetch_valid     (fetch_valid),
      .fetch_addr      (fetch_addr),
      .fetch_ready     (fetch_ready),
      .fetch_rsp_valid (fetch_rsp_valid),
      .fetch_rsp_rdata (fetch_rsp_rdata)
   );

   interrupt_unit i_interrupt_unit (
      .clk          (clk),
      .arst_n       (arst_n),
      .io_req       (io_req),
      .io_rsp_valid (io_rsp_valid),
      .io_rsp_rdata (io_rsp_rdata),
      .irq_lines    (irq_lines),
      .interrupt    (interrupt)
   );

   // Issue strobe is the data port handshake
   response_merger i_response_merger (
      .clk           (clk),
      .arst_n        (arst_n),
      .mem_rsp_valid (mem_rsp_valid),
      .mem_rsp_rdata (mem_rsp_rdata),
      .io_rsp_valid  (io_rsp_valid),
      .io_rsp_rdata  (io_rsp_rdata),
      .issue         (req_valid & req_ready),
      .credit_ok     (credit_ok),
      .rsp_valid     (rsp_valid),
      .rsp_rdata     (rsp_rdata),
      .rsp_ready     (rsp_ready)
   );

endmodule

`default_nettype wire

//--- verilog/mem_subsystem_pkg.sv
`default_nettype none

package mem_subsystem_pkg;

   // Line geometry
   localparam int LINE_ADDR_W = 16;
   localparam int LINE_W      = 128;
   localparam int IRQ_W       = 8;

   typedef logic [LINE_ADDR_W-1:0] line_addr_t;
   typedef logic [LINE_W-1:0]      line_data_t;
   typedef logic [IRQ_W-1:0]       irq_vec_t;

   // Where a data request is steered
   typedef enum logic {
      tgt_mem,
      tgt_io
   } target_t;

   // IO space is every line address with bits 14..12 all set
   localparam int IO_SEL_MSB = 14;
   localparam int IO_SEL_LSB = 12;

   // Register offsets inside IO space, taken from address bit 0
   localparam logic IO_REG_MASK    = 1'b0;
   localparam logic IO_REG_PENDING = 1'b1;

   // Line memory, indexed by the low address bits
   localparam int MEM_DEPTH = 256;
   localparam int MEM_IDX_W = $clog2(MEM_DEPTH);
   typedef logic [MEM_IDX_W-1:0] mem_idx_t;

   // Response queue, also the bound on outstanding data requests
   localparam int RSP_DEPTH = 4;
   localparam int RSP_PTR_W = $clog2(RSP_DEPTH);
   localparam int RSP_CNT_W = $clog2(RSP_DEPTH + 1);
   typedef logic [RSP_PTR_W-1:0] rsp_ptr_t;
   typedef logic [RSP_CNT_W-1:0] rsp_cnt_t;

endpackage

`default_nettype wire

//--- verilog/response_merger.sv
`timescale 1ns/1ps
`default_nettype none

module response_merger (
   input  wire                              clk,
   input  wire                              arst_n,
   input  wire                              mem_rsp_valid,
   input  wire mem_subsystem_pkg::line_data_t mem_rsp_rdata,
   input  wire                              io_rsp_valid,
   input  wire mem_subsystem_pkg::line_data_t io_rsp_rdata,
   input  wire                              issue,
   output logic                             credit_ok,
   output logic                             rsp_valid,
   output mem_subsystem_pkg::line_data_t    rsp_rdata,
   input  wire                              rsp_ready
);

   mem_subsystem_pkg::line_data_t fifo [mem_subsystem_pkg::RSP_DEPTH];

   mem_subsystem_pkg::rsp_ptr_t   wr_ptr;
   mem_subsystem_pkg::rsp_ptr_t   rd_ptr;
   mem_subsystem_pkg::rsp_cnt_t   fill;
   mem_subsystem_pkg::rsp_cnt_t   outstanding;
   mem_subsystem_pkg::line_data_t push_data;
   logic                          push;
   logic                          pop;

   // At most one target answers per cycle
   assign push      = mem_rsp_valid | io_rsp_valid;
   assign push_data = io_rsp_valid ? io_rsp_rdata : mem_rsp_rdata;

   assign rsp_valid = (fill != '0);
   assign rsp_rdata = fifo[rd_ptr];
   assign pop       = rsp_valid & rsp_ready;

   // Credit covers requests in flight plus entries still queued
   assign credit_ok = outstanding <
                      mem_subsystem_pkg::rsp_cnt_t'(mem_subsystem_pkg::RSP_DEPTH);

   always_ff @(posedge clk) begin
      if (push) begin
         fifo[wr_ptr] <= push_data;
      end
   end

   // Pointers wrap on their own, depth is a power of two
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         fill <= '0;
      end else begin
         case ({push, pop})
            2'b10:   fill <= fill + 1'b1;
            2'b01:   fill <= fill - 1'b1;
            default: fill <= fill;
         endcase
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         outstanding <= '0;
      end else begin
         case ({issue, pop})
            2'b10:   outstanding <= outstanding + 1'b1;
            2'b01:   outstanding <= outstanding - 1'b1;
            default: outstanding <= outstanding;
         endcase
      end
   end

   a_single_source: assert property (
      @(posedge clk) disable iff (!arst_n)
      !(mem_rsp_valid && io_rsp_valid)
   ) else $error("memory and IO responses in the same cycle");

   // Credit accounting must keep the queue from filling past its depth
   a_no_overflow: assert property (
      @(posedge clk) disable iff (!arst_n)
      push |-> (fill < mem_subsystem_pkg::rsp_cnt_t'(mem_subsystem_pkg::RSP_DEPTH))
   ) else $error("response queue overflow");

endmodule

`default_nettype wire
